/* Makefile */
# Verilator build and run for the elevator floor request logic

VERILATOR ?= verilator
TOP       ?= floor_logic_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= all tests passed
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# Fails unless the pass message appears on a line of its own
run: $(BIN)
	@output="$$($(BIN) 2>&1)"; \
	echo "$$output"; \
	echo "$$output" | grep -qxF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* files.f */
src/floor_pkg.sv
src/car_pkg.sv
src/request_if.sv
src/scan_if.sv
src/request_register.sv
src/floor_scanner.sv
src/dispatch_control.sv
src/floor_logic_top.sv
verification/floor_logic_tb.sv

/* src/car_pkg.sv */
`default_nettype none

package car_pkg;

    ////////////////////////////////////////
    // Travel direction
    ////////////////////////////////////////

    // Direction the car serves requests in
    typedef enum logic {
        dir_down = 1'b0,
        dir_up   = 1'b1
    } direction_t;

    // The car starts out serving upward requests
    localparam direction_t reset_direction = dir_up;

endpackage

`default_nettype wire

/* src/dispatch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module dispatch_control import floor_pkg::*, car_pkg::*; (
    input  wire         clock,
    input  wire         reset_n,
    input  wire         emergency_button,
    input  wire         power_switch,
    input  wire         car_moving,
    input  wire floor_t current_floor,
    input  wire         door_open_button,
    input  wire         door_close_button,
    request_if.control  requests,
    scan_if.control     scan,
    output floor_t      target_floor,
    output direction_t  direction,
    output logic        start_car,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic       run_enable;
    logic       stopped_powered;
    direction_t next_direction;
    floor_t     next_target;
    logic       next_start;

    // Car may run when powered and no emergency is active
    assign run_enable      = power_switch & ~emergency_button;
    assign stopped_powered = power_switch & ~car_moving;

    assign requests.accept_enable = run_enable;
    assign requests.clear_enable  = stopped_powered;

    ////////////////////////////////////////
    // Direction and target selection
    ////////////////////////////////////////

    // Reverse only when nothing is left ahead and something waits behind
    always_comb begin
        next_direction = direction;
        case (direction)
            dir_up: begin
                if (!scan.any_above && scan.any_below) begin
                    next_direction = dir_down;
                end
            end
            default: begin
                if (!scan.any_below && scan.any_above) begin
                    next_direction = dir_up;
                end
            end
        endcase
    end

    // The scanner reports current_floor for an empty side
    assign next_target = (direction == dir_up) ? scan.nearest_above : scan.nearest_below;

    assign next_start = run_enable & ~car_moving & (next_target != current_floor);

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            direction          <= reset_direction;
            target_floor       <= '0;
            start_car          <= 1'b0;
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            direction    <= next_direction;
            target_floor <= next_target;
            start_car    <= next_start;
            // Door buttons count only while stopped with power on
            door_open_allowed  <= door_open_button & stopped_powered;
            door_close_allowed <= door_close_button & stopped_powered;
        end
    end

    assign scan.direction = direction;

endmodule

`default_nettype wire

/* src/floor_logic_top.sv */
`timescale 1ns/1ps
`default_nettype none

module floor_logic_top import floor_pkg::*, car_pkg::*; (
    input  wire              clock,
    input  wire              reset_n,
    input  wire floor_mask_t hall_buttons,
    input  wire floor_mask_t car_buttons,
    input  wire              door_open_button,
    input  wire              door_close_button,
    input  wire              emergency_button,
    input  wire              power_switch,
    input  wire floor_t      current_floor,
    input  wire              car_moving,
    output floor_mask_t      hall_lights,
    output floor_mask_t      car_lights,
    output floor_t           target_floor,
    output direction_t       direction,
    output logic             start_car,
    output logic             door_open_allowed,
    output logic             door_close_allowed
);

    request_if request_bus ();
    scan_if    scan_bus ();

    // Request lights, set by buttons and cleared on arrival
    request_register i_request_register (
        .clock         (clock),
        .reset_n       (reset_n),
        .hall_buttons  (hall_buttons),
        .car_buttons   (car_buttons),
        .current_floor (current_floor),
        .bank          (request_bus.bank)
    );

    floor_scanner i_floor_scanner (
        .hall_lights   (request_bus.hall_lights),
        .car_lights    (request_bus.car_lights),
        .current_floor (current_floor),
        .scan          (scan_bus.scanner)
    );

    dispatch_control i_dispatch_control (
        .clock              (clock),
        .reset_n            (reset_n),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .car_moving         (car_moving),
        .current_floor      (current_floor),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .requests           (request_bus.control),
        .scan               (scan_bus.control),
        .target_floor       (target_floor),
        .direction          (direction),
        .start_car          (start_car),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    assign hall_lights = request_bus.hall_lights;
    assign car_lights  = request_bus.car_lights;

endmodule

`default_nettype wire

/* src/floor_pkg.sv */
`default_nettype none

package floor_pkg;

    ////////////////////////////////////////
    // Floor numbering
    ////////////////////////////////////////

    // Floors served by the car
    localparam int num_floors = 11;

    // Width of a floor index, enough for index 10
    localparam int floor_bits = 4;

    ////////////////////////////////////////
    // Floor types
    ////////////////////////////////////////

    // Floor 1 is index 0, floor 11 is index 10
    typedef logic [floor_bits-1:0] floor_t;

    // One request bit per floor, bit i is floor index i
    typedef logic [num_floors-1:0] floor_mask_t;

endpackage

`default_nettype wire

/* src/floor_scanner.sv */
`timescale 1ns/1ps
`default_nettype none

module floor_scanner import floor_pkg::*; (
    input  wire floor_mask_t hall_lights,
    input  wire floor_mask_t car_lights,
    input  wire floor_t current_floor,
    scan_if.scanner     scan
);

    floor_mask_t pending;
    floor_mask_t above_mask;
    floor_mask_t below_mask;
    floor_t      nearest_above;
    floor_t      nearest_below;

    // A floor is pending when either light is on
    assign pending = hall_lights | car_lights;

    ////////////////////////////////////////
    // Side masks
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < num_floors; i++) begin
            above_mask[i] = floor_t'(i) > current_floor;
            below_mask[i] = floor_t'(i) < current_floor;
        end
    end

    ////////////////////////////////////////
    // Nearest request on each side
    ////////////////////////////////////////

    // Walk down from the top so the lowest floor above wins
    always_comb begin
        nearest_above = current_floor;
        for (int i = num_floors - 1; i >= 0; i--) begin
            if (pending[i] && above_mask[i]) begin
                nearest_above = floor_t'(i);
            end
        end
    end

    // Walk up from the bottom so the highest floor below wins
    always_comb begin
        nearest_below = current_floor;
        for (int i = 0; i < num_floors; i++) begin
            if (pending[i] && below_mask[i]) begin
                nearest_below = floor_t'(i);
            end
        end
    end

    assign scan.any_above     = |(pending & above_mask);
    assign scan.any_below     = |(pending & below_mask);
    assign scan.nearest_above = nearest_above;
    assign scan.nearest_below = nearest_below;

endmodule

`default_nettype wire

/* src/request_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Request lights and their enables between the register and the controller
interface request_if import floor_pkg::*; ();

    // Lit hall call and car panel requests
    floor_mask_t hall_lights;
    floor_mask_t car_lights;

    // New presses are taken only when this is high
    logic accept_enable;

    // Lights at the current floor are cleared when this is high
    logic clear_enable;

    modport bank (
        output hall_lights,
        output car_lights,
        input  accept_enable,
        input  clear_enable
    );

    modport control (
        output accept_enable,
        output clear_enable
    );

endinterface

`default_nettype wire

/* src/request_register.sv */
`timescale 1ns/1ps
`default_nettype none

module request_register import floor_pkg::*; (
    input  wire         clock,
    input  wire         reset_n,
    input  wire floor_mask_t hall_buttons,
    input  wire floor_mask_t car_buttons,
    input  wire floor_t current_floor,
    request_if.bank     bank
);

    floor_mask_t hall_q;
    floor_mask_t car_q;
    floor_mask_t here_mask;
    floor_mask_t accept_mask;
    floor_mask_t clear_mask;

    // Set on a press, clear on arrival
    function automatic floor_mask_t next_lights(
        input floor_mask_t lights,
        input floor_mask_t buttons,
        input floor_mask_t accept,
        input floor_mask_t clear
    );
        return (lights | (buttons & accept)) & ~clear;
    endfunction

    ////////////////////////////////////////
    // Set and clear masks
    ////////////////////////////////////////

    // One hot mask of the floor the car stands at
    assign here_mask = floor_mask_t'(1) << current_floor;

    // A press at the car's own floor never lights
    assign accept_mask = bank.accept_enable ? ~here_mask : '0;
    assign clear_mask  = bank.clear_enable ? here_mask : '0;

    ////////////////////////////////////////
    // Light registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            hall_q <= '0;
            car_q  <= '0;
        end else begin
            hall_q <= next_lights(hall_q, hall_buttons, accept_mask, clear_mask);
            car_q  <= next_lights(car_q, car_buttons, accept_mask, clear_mask);
        end
    end

    assign bank.hall_lights = hall_q;
    assign bank.car_lights  = car_q;

endmodule

`default_nettype wire

/* src/scan_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Scan results toward the controller, direction back to the scanner
interface scan_if import floor_pkg::*, car_pkg::*; ();

    // Current travel direction from the direction register
    direction_t direction;

    // Pending requests on either side of the car
    logic any_above;
    logic any_below;

    // Nearest pending floor on each side, current floor when a side is empty
    floor_t nearest_above;
    floor_t nearest_below;

    modport scanner (
        input  direction,
        output any_above,
        output any_below,
        output nearest_above,
        output nearest_below
    );

    modport control (
        output direction,
        input  any_above,
        input  any_below,
        input  nearest_above,
        input  nearest_below
    );

endinterface

`default_nettype wire

/* verification/floor_logic_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb import floor_pkg::*, car_pkg::*; ();

    localparam int    clock_period  = 40;
    localparam int    reset_cycles  = 10;
    localparam int    margin_cycles = 20;
    localparam int    field_count   = 16;
    localparam string vector_path   = "verification/floor_logic_tests.txt";

    // One line of the vector file: inputs, hold count, expected outputs
    typedef struct packed {
        floor_mask_t hall_buttons;
        floor_mask_t car_buttons;
        logic        door_open_button;
        logic        door_close_button;
        logic        emergency_button;
        logic        power_switch;
        floor_t      current_floor;
        logic        car_moving;
        logic [7:0]  hold_cycles;
        floor_mask_t hall_lights;
        floor_mask_t car_lights;
        floor_t      target_floor;
        logic        direction;
        logic        start_car;
        logic        door_open_allowed;
        logic        door_close_allowed;
    } step_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t hall_buttons;
    floor_mask_t car_buttons;
    logic        door_open_button;
    logic        door_close_button;
    logic        emergency_button;
    logic        power_switch;
    floor_t      current_floor;
    logic        car_moving;
    floor_mask_t hall_lights;
    floor_mask_t car_lights;
    floor_t      target_floor;
    direction_t  direction;
    logic        start_car;
    logic        door_open_allowed;
    logic        door_close_allowed;

    step_t steps[$];
    int    step_index;
    int    hold_total;
    int    watchdog_cycles;
    bit    vectors_loaded = 1'b0;

    floor_logic_top i_dut (
        .clock              (clock),
        .reset_n            (reset_n),
        .hall_buttons       (hall_buttons),
        .car_buttons        (car_buttons),
        .door_open_button   (door_open_button),
        .door_close_button  (door_close_button),
        .emergency_button   (emergency_button),
        .power_switch       (power_switch),
        .current_floor      (current_floor),
        .car_moving         (car_moving),
        .hall_lights        (hall_lights),
        .car_lights         (car_lights),
        .target_floor       (target_floor),
        .direction          (direction),
        .start_car          (start_car),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

    always #(clock_period / 2) clock = ~clock;

    ////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////

    // Comment and blank lines match no field and are skipped
    task automatic load_vectors();
        logic [8*256-1:0] text_line;
        logic [31:0] v_hall, v_car, v_open, v_close, v_emergency, v_power, v_floor, v_moving;
        logic [31:0] v_hold, e_hall, e_car, e_target, e_direction, e_start, e_open, e_close;
        step_t step;
        int    fd;
        int    code;
        int    line_number;

        fd = $fopen(vector_path, "r");
        if (fd == 0) begin
            $display("Could not open the test vector file %s", vector_path);
            $display("tests failed");
            $fatal(1, "Missing test vector file");
        end else begin
            line_number = 0;
            while (!$feof(fd)) begin
                text_line = '0;
                code = $fgets(text_line, fd);
                line_number++;
                if (code > 0) begin
                    code = $sscanf(text_line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_hall, v_car, v_open, v_close, v_emergency, v_power, v_floor,
                        v_moving, v_hold, e_hall, e_car, e_target, e_direction, e_start,
                        e_open, e_close);
                    if (code == field_count) begin
                        step.hall_buttons       = floor_mask_t'(v_hall);
                        step.car_buttons        = floor_mask_t'(v_car);
                        step.door_open_button   = v_open[0];
                        step.door_close_button  = v_close[0];
                        step.emergency_button   = v_emergency[0];
                        step.power_switch       = v_power[0];
                        step.current_floor      = floor_t'(v_floor);
                        step.car_moving         = v_moving[0];
                        step.hold_cycles        = v_hold[7:0];
                        step.hall_lights        = floor_mask_t'(e_hall);
                        step.car_lights         = floor_mask_t'(e_car);
                        step.target_floor       = floor_t'(e_target);
                        step.direction          = e_direction[0];
                        step.start_car          = e_start[0];
                        step.door_open_allowed  = e_open[0];
                        step.door_close_allowed = e_close[0];
                        steps.push_back(step);
                        hold_total += int'(v_hold[7:0]);
                    end else if (code > 0) begin
                        $display("Line %0d of %s has %0d fields instead of %0d",
                            line_number, vector_path, code, field_count);
                        $display("tests failed");
                        $fatal(1, "Malformed test vector line");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////
    // Drive and check
    ////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0d ns, step %0d: %s expected %0h, actual %0h",
                $time, step_index, name, expected, actual);
            $display("tests failed");
            $fatal(1, "Output mismatch on %s", name);
        end
    endtask

    task automatic apply_step(input step_t s);
        hall_buttons      = s.hall_buttons;
        car_buttons       = s.car_buttons;
        door_open_button  = s.door_open_button;
        door_close_button = s.door_close_button;
        emergency_button  = s.emergency_button;
        power_switch      = s.power_switch;
        current_floor     = s.current_floor;
        car_moving        = s.car_moving;
    endtask

    task automatic check_step(input step_t s);
        check_value("hall_lights", 32'(hall_lights), 32'(s.hall_lights));
        check_value("car_lights", 32'(car_lights), 32'(s.car_lights));
        check_value("target_floor", 32'(target_floor), 32'(s.target_floor));
        check_value("direction", 32'(direction), 32'(s.direction));
        check_value("start_car", 32'(start_car), 32'(s.start_car));
        check_value("door_open_allowed", 32'(door_open_allowed), 32'(s.door_open_allowed));
        check_value("door_close_allowed", 32'(door_close_allowed), 32'(s.door_close_allowed));
    endtask

    // Everything clear and heading up while reset is held
    task automatic check_reset_state();
        check_value("hall_lights", 32'(hall_lights), 32'(0));
        check_value("car_lights", 32'(car_lights), 32'(0));
        check_value("target_floor", 32'(target_floor), 32'(0));
        check_value("direction", 32'(direction), 32'(dir_up));
        check_value("start_car", 32'(start_car), 32'(0));
        check_value("door_open_allowed", 32'(door_open_allowed), 32'(0));
        check_value("door_close_allowed", 32'(door_close_allowed), 32'(0));
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        clock             = 1'b0;
        reset_n           = 1'b0;
        hall_buttons      = '0;
        car_buttons       = '0;
        door_open_button  = 1'b0;
        door_close_button = 1'b0;
        emergency_button  = 1'b0;
        power_switch      = 1'b0;
        current_floor     = '0;
        car_moving        = 1'b0;
        step_index        = 0;
        hold_total        = 0;
        load_vectors();
        watchdog_cycles = reset_cycles + hold_total + margin_cycles;
        vectors_loaded  = 1'b1;

        repeat (reset_cycles) @(negedge clock);
        check_reset_state();
        reset_n = 1'b1;

        // Inputs change on the falling edge, outputs are read there too
        foreach (steps[i]) begin
            step_index = i + 1;
            apply_step(steps[i]);
            repeat (steps[i].hold_cycles) @(posedge clock);
            @(negedge clock);
            check_step(steps[i]);
        end

        if (steps.size() == 0) begin
            $display("No test vectors were found in %s", vector_path);
            $display("tests failed");
            $fatal(1, "Empty test vector file");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

    // Watchdog sized from the hold counts in the vector file
    initial begin
        wait (vectors_loaded);
        #(watchdog_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d clock cycles", watchdog_cycles);
        $display("tests failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* verification/floor_logic_tests.txt */
# hall car door_open door_close emergency power floor moving hold, then expected
# hall_lights car_lights target direction start door_open_ok door_close_ok (all hex)
# Idle, power off, emergency, press at the car's own floor
000 000 0 0 0 0 0 0 1   000 000 0 1 0 0 0
004 010 0 0 0 0 0 0 1   000 000 0 1 0 0 0
004 010 0 0 1 1 0 0 1   000 000 0 1 0 0 0
008 008 0 0 0 1 3 0 1   000 000 3 1 0 0 0
# Requests at 1, 6 and 9 with the car stopped at 3
042 240 0 0 0 1 3 0 1   042 240 3 1 0 0 0
000 000 0 0 0 1 3 0 3   042 240 6 1 1 0 0
000 000 1 1 0 1 3 1 1   042 240 6 1 0 0 0
# Arrival at 6 clears both lights, door buttons while stopped
000 000 0 0 0 1 6 0 1   002 200 9 1 1 0 0
000 000 1 0 0 1 6 0 1   002 200 9 1 1 1 0
000 000 0 1 0 1 6 0 1   002 200 9 1 1 0 1
000 000 1 1 0 0 6 0 1   002 200 9 1 0 0 0
# Arrival at 9 with only floor 1 left, direction turns down
000 000 0 0 0 1 9 0 1   002 000 9 0 0 0 0
000 000 0 0 0 1 9 0 1   002 000 1 0 1 0 0
000 000 0 0 0 1 5 1 1   002 000 1 0 0 0 0
100 008 0 0 0 1 5 1 1   102 008 1 0 0 0 0
000 000 0 0 0 1 5 1 1   102 008 3 0 0 0 0
000 000 0 0 0 1 3 0 3   102 000 1 0 1 0 0
000 000 0 0 0 1 1 0 3   100 000 8 1 1 0 0
# Requests only below the car at 8
000 000 0 0 0 1 8 0 1   000 000 8 1 0 0 0
004 020 0 0 0 1 8 0 1   004 020 8 1 0 0 0
000 000 0 0 0 1 8 0 3   004 020 5 0 1 0 0
400 000 1 0 1 1 8 0 1   004 020 5 0 0 1 0
000 000 0 0 0 1 8 0 1   004 020 5 0 1 0 0
000 000 0 0 0 1 5 0 3   004 000 2 0 1 0 0
000 000 0 0 0 1 2 0 3   000 000 2 0 0 0 0
# Power off doors, then a top floor call turns the car up
000 000 1 1 0 0 2 0 1   000 000 2 0 0 0 0
400 000 0 0 0 1 2 0 1   400 000 2 0 0 0 0
000 000 0 0 0 1 2 0 3   400 000 a 1 1 0 0
